// ==== Makefile ====
VERILATOR ?= verilator
TOP ?= core_tb
RTL_TOP ?= core_top
FILELIST ?= compile.f
OBJ_DIR ?= obj_dir
BUILD_FLAGS ?= --binary --timing --assert -j 0
LINT_FLAGS ?= --lint-only

RTL_FILES := $(shell grep '^verilog/' $(FILELIST))

.PHONY: all build run lint clean

all: run

build:
	$(VERILATOR) $(BUILD_FLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FILELIST)

run: build
	@out="$$(./$(OBJ_DIR)/V$(TOP) 2>&1)"; \
	echo "$$out"; \
	echo "$$out" | grep -q '^Testbench passed$$'

lint:
	$(VERILATOR) $(LINT_FLAGS) --top-module $(RTL_TOP) $(RTL_FILES)

clean:
	rm -rf $(OBJ_DIR)

// ==== compile.f ====
verilog/core_pkg.sv
verilog/core_regfile.sv
verilog/core_fetch.sv
verilog/core_decode.sv
verilog/core_execute.sv
verilog/core_top.sv
sim/core_chk.sv
sim/core_tb.sv

// ==== sim/core_chk.sv ====
`timescale 1ns/100ps

module core_chk
	import core_pkg::*;
(
	input logic clk,
	input logic reset,
	input reg_write_t reg_write,
	input logic halt
);

	// r0 is hardwired to zero, so no write to it may leave the core
	no_r0_write: assert property (
		@(posedge clk) disable iff (reset)
		reg_write.wen |-> reg_write.addr != '0
	) else $error("reg_write to r0");

	no_write_when_halted: assert property (
		@(posedge clk) disable iff (reset)
		halt |-> !reg_write.wen
	) else $error("reg_write.wen high while halted");

	// Halt is sticky and only reset clears it
	halt_held: assert property (
		@(posedge clk)
		$fell(halt) |-> reset
	) else $error("halt fell outside reset");

endmodule

bind core_top core_chk chk_i (
	.clk(clk),
	.reset(reset),
	.reg_write(reg_write),
	.halt(halt)
);

// ==== sim/core_tb.sv ====
`timescale 1ns/100ps

module core_tb
	import core_pkg::*;
();

	logic clk = 1'b0;
	logic reset = 1'b1;
	word_t imem_data = '0;
	imem_addr_t imem_addr;
	reg_write_t reg_write;
	logic halt;

	word_t mem [0:32767];
	word_t prog [$];
	reg_write_t exp_q [$];
	reg_write_t expected_write;
	int writes_seen = 0;
	logic [31:0] lcg_state = 32'd10594;

	core_top core_top_i (
		.clk(clk),
		.reset(reset),
		.imem_addr(imem_addr),
		.imem_data(imem_data),
		.reg_write(reg_write),
		.halt(halt)
	);

	initial begin
		forever #5 clk = ~clk;
	end

	// Instruction memory answers one cycle after the address
	always @(posedge clk) begin
		imem_data <= mem[imem_addr];
	end

	task automatic stop_with_failure(string reason);
		$display("%s", reason);
		$display("Testbench failed");
		$fatal(1, "Stopped at the first error");
	endtask

	task automatic check_value(string name, logic [31:0] got, logic [31:0] expected);
		if (got !== expected) begin
			stop_with_failure($sformatf("MISMATCH time=%0t %s got=%0h expected=%0h",
				$time, name, got, expected));
		end
	endtask

	function automatic logic [15:0] next_random();
		lcg_state = lcg_state * 32'd1103515245 + 32'd12345;
		return lcg_state[31:16];
	endfunction

	function automatic word_t rr_instr(opcode_t op, reg_addr_t ra, reg_addr_t rb, reg_addr_t rt);
		return {op, ra, rb, rt};
	endfunction

	function automatic word_t imm_instr(opcode_t op, imm_t imm, reg_addr_t rt);
		return {op, imm, rt};
	endfunction

	function automatic word_t jump_instr(xop_t xop, reg_addr_t ra, reg_addr_t rt);
		return {op_jump, ra, xop, rt};
	endfunction

	// Architectural model of the ISA, run over the loaded memory
	function automatic bit reference_run();
		word_t regs [16];
		pc_t pc;
		word_t instr;
		opcode_t op;
		xop_t xop;
		reg_addr_t ra;
		reg_addr_t rb;
		reg_addr_t rt;
		imm_t imm;
		word_t result;
		logic writes;
		logic taken;
		reg_write_t w;
		int i;
		int step;
		exp_q.delete();
		for (i = 0; i < 16; i++) begin
			regs[i] = '0;
		end
		pc = '0;
		for (step = 0; step < 4096; step++) begin
			instr = mem[pc[15:1]];
			op = instr[15:12];
			ra = instr[11:8];
			rb = instr[7:4];
			rt = instr[3:0];
			xop = instr[7:4];
			imm = instr[11:4];
			writes = 1'b1;
			taken = 1'b0;
			result = '0;
			case (op)
				op_sub: result = regs[ra] - regs[rb];
				op_add: result = regs[ra] + regs[rb];
				op_inc: result = regs[rt] + {8'h00, imm};
				op_dec: result = regs[rt] - {8'h00, imm};
				op_cmp: result = (regs[ra] == regs[rb]) ? 16'd1 : 16'd0;
				op_movl: result = {{8{imm[7]}}, imm};
				op_movh: result = {imm, regs[rt][7:0]};
				op_jump: begin
					writes = 1'b0;
					case (xop)
						xop_jz: taken = regs[ra] == 16'd0;
						xop_jnz: taken = regs[ra] != 16'd0;
						xop_js: taken = regs[ra][15];
						xop_jns: taken = !regs[ra][15];
						default: return 1'b1;
					endcase
				end
				default: return 1'b1;
			endcase
			if (writes && rt != 4'd0) begin
				regs[rt] = result;
				w.wen = 1'b1;
				w.addr = rt;
				w.data = result;
				exp_q.push_back(w);
			end
			pc = taken ? regs[rt] : pc + 16'd2;
		end
		return 1'b0;
	endfunction

	// Unused words decode as an invalid opcode that depends on the full address
	task automatic load_program();
		int a;
		imem_addr_t addr;
		for (a = 0; a < 32768; a++) begin
			addr = imem_addr_t'(a);
			mem[addr] = {4'hF, addr[11:0] ^ {9'd0, addr[14:12]}};
		end
		for (a = 0; a < prog.size(); a++) begin
			mem[a] = prog[a];
		end
	endtask

	task automatic build_random_program(int length);
		int i;
		opcode_t op;
		reg_addr_t ra;
		reg_addr_t rb;
		reg_addr_t rt;
		prog.delete();
		for (i = 1; i < 16; i++) begin
			prog.push_back(imm_instr(op_movl, imm_t'(next_random()), reg_addr_t'(i)));
		end
		for (i = 0; i < length; i++) begin
			case (next_random() % 16'd7)
				16'd0: op = op_sub;
				16'd1: op = op_add;
				16'd2: op = op_inc;
				16'd3: op = op_dec;
				16'd4: op = op_cmp;
				16'd5: op = op_movl;
				default: op = op_movh;
			endcase
			// Few registers, so dependences and r0 targets come up often
			ra = reg_addr_t'(next_random() % 16'd6);
			rb = reg_addr_t'(next_random() % 16'd6);
			rt = reg_addr_t'(next_random() % 16'd6);
			if (op == op_sub || op == op_add || op == op_cmp)
				prog.push_back(rr_instr(op, ra, rb, rt));
			else
				prog.push_back(imm_instr(op, imm_t'(next_random()), rt));
		end
		prog.push_back(16'hF000);
	endtask

	task automatic build_directed_program();
		prog.delete();
		prog.push_back(imm_instr(op_movl, 8'h05, 4'd1));
		prog.push_back(imm_instr(op_movl, 8'h05, 4'd2));
		prog.push_back(rr_instr(op_cmp, 4'd1, 4'd2, 4'd3));
		prog.push_back(imm_instr(op_movl, 8'h06, 4'd4));
		prog.push_back(rr_instr(op_cmp, 4'd1, 4'd4, 4'd5));
		prog.push_back(imm_instr(op_movl, 8'hF0, 4'd6));
		prog.push_back(imm_instr(op_movh, 8'h12, 4'd6));
		prog.push_back(imm_instr(op_movl, 8'h00, 4'd7));
		prog.push_back(imm_instr(op_inc, 8'hC8, 4'd7));
		prog.push_back(imm_instr(op_dec, 8'hFF, 4'd7));
		prog.push_back(rr_instr(op_sub, 4'd7, 4'd6, 4'd8));
		prog.push_back(rr_instr(op_cmp, 4'd0, 4'd0, 4'd9));
		prog.push_back(16'hF000);
	endtask

	// Each case rejoins at its target, so both outcomes run the same tail
	task automatic build_jump_program();
		int c;
		xop_t xop;
		imm_t cond_val;
		pc_t target;
		prog.delete();
		for (c = 0; c < 8; c++) begin
			xop = xop_t'(c / 2);
			case (xop)
				xop_jz: cond_val = (c % 2 == 0) ? 8'h00 : 8'h05;
				xop_jnz: cond_val = (c % 2 == 0) ? 8'h05 : 8'h00;
				xop_js: cond_val = (c % 2 == 0) ? 8'h80 : 8'h05;
				default: cond_val = (c % 2 == 0) ? 8'h05 : 8'h80;
			endcase
			target = pc_t'((prog.size() + 6) * 2);
			prog.push_back(imm_instr(op_movl, cond_val, 4'd1));
			prog.push_back(imm_instr(op_movl, target[7:0], 4'd2));
			prog.push_back(imm_instr(op_movh, target[15:8], 4'd2));
			prog.push_back(jump_instr(xop, 4'd1, 4'd2));
			prog.push_back(imm_instr(op_movl, 8'h11, 4'd3));
			prog.push_back(imm_instr(op_movl, 8'h22, 4'd4));
			prog.push_back(imm_instr(op_movl, imm_t'(c), 4'd5));
		end
		prog.push_back(16'hF000);
	endtask

	task automatic build_loop_program(imm_t count);
		prog.delete();
		prog.push_back(imm_instr(op_movl, count, 4'd1));
		prog.push_back(imm_instr(op_movl, 8'h00, 4'd2));
		// The loop body starts at byte address 6
		prog.push_back(imm_instr(op_movl, 8'h06, 4'd3));
		prog.push_back(imm_instr(op_inc, 8'h03, 4'd2));
		prog.push_back(imm_instr(op_dec, 8'h01, 4'd1));
		prog.push_back(jump_instr(xop_jnz, 4'd1, 4'd3));
		prog.push_back(imm_instr(op_movl, 8'h55, 4'd4));
		prog.push_back(16'hF000);
	endtask

	task automatic run_program(string label);
		int cycles;
		load_program();
		if (!reference_run())
			stop_with_failure({"Reference model never reached a halt in ", label});
		writes_seen = 0;
		@(posedge clk);
		reset <= 1'b1;
		repeat (5) @(posedge clk);
		check_value("imem_addr", 32'(imem_addr), 32'd0);
		check_value("reg_write.wen", 32'(reg_write.wen), 32'd0);
		check_value("halt", 32'(halt), 32'd0);
		reset <= 1'b0;
		cycles = 0;
		while (halt !== 1'b1 && cycles < 2000) begin
			@(posedge clk);
			cycles++;
		end
		if (halt !== 1'b1) begin
			stop_with_failure({"Timed out waiting for halt in ", label});
		end else begin
			repeat (3) @(posedge clk);
			check_value("pending writes", 32'(exp_q.size()), 32'd0);
		end
	endtask

	// Every write strobe must match the next write of the reference
	always @(posedge clk) begin
		if (!reset && reg_write.wen === 1'b1) begin
			if (halt === 1'b1) begin
				stop_with_failure("Register write seen while the core is halted");
			end else if (exp_q.size() == 0) begin
				stop_with_failure("Register write seen with no write left to expect");
			end else begin
				expected_write = exp_q.pop_front();
				check_value("reg_write.addr", 32'(reg_write.addr), 32'(expected_write.addr));
				check_value("reg_write.data", 32'(reg_write.data), 32'(expected_write.data));
				writes_seen++;
			end
		end
	end

	initial begin
		int i;
		for (i = 0; i < 3; i++) begin
			build_random_program(40);
			run_program("random program");
		end
		build_directed_program();
		run_program("ALU corner cases");
		build_jump_program();
		run_program("conditional jumps");
		build_loop_program(8'd7);
		run_program("countdown loop");
		// Three setup writes, two per pass and one after the loop
		check_value("loop write count", 32'(writes_seen), 32'd18);
		$display("Testbench passed");
		$finish;
	end

endmodule

// ==== verilog/core_decode.sv ====
`timescale 1ns/100ps

module core_decode
	import core_pkg::*;
(
	input logic clk,
	input logic reset,
	input logic halt,
	input redirect_t redirect,
	input pc_t fetch_pc,
	input logic fetch_valid,
	input word_t imem_data,
	input reg_write_t ex_result,
	input reg_write_t wb_write,
	output decoded_t decoded
);

	opcode_t opcode;
	reg_addr_t ra;
	reg_addr_t rb;
	reg_addr_t rt;
	reg_addr_t rd_addr_b;
	logic use_rb;
	word_t rf_data_a;
	word_t rf_data_b;
	word_t opnd_a;
	word_t opnd_b;
	decoded_t dec_next;

	assign opcode = imem_data[15:12];
	assign ra = imem_data[11:8];
	assign rb = imem_data[7:4];
	assign rt = imem_data[3:0];

	// Only the two-register ALU instructions read rb; the rest read rt
	assign use_rb = opcode == op_sub || opcode == op_add || opcode == op_cmp;
	assign rd_addr_b = use_rb ? rb : rt;

	core_regfile regfile_i (
		.clk(clk),
		.rd_addr_a(ra),
		.rd_addr_b(rd_addr_b),
		.rd_data_a(rf_data_a),
		.rd_data_b(rf_data_b),
		.write(wb_write)
	);

	// The instruction in execute is the only producer the register file
	// cannot see yet
	function automatic word_t forward(reg_addr_t src, word_t rf_data);
		if (ex_result.wen && ex_result.addr == src)
			return ex_result.data;
		return rf_data;
	endfunction

	assign opnd_a = forward(ra, rf_data_a);
	assign opnd_b = forward(rd_addr_b, rf_data_b);

	always_comb begin
		dec_next.valid = fetch_valid && !redirect.en;
		dec_next.pc = fetch_pc;
		dec_next.opcode = opcode;
		dec_next.xop = imem_data[7:4];
		dec_next.imm = imem_data[11:4];
		dec_next.rt = rt;
		dec_next.va = opnd_a;
		dec_next.vb = use_rb ? opnd_b : '0;
		dec_next.vt = use_rb ? '0 : opnd_b;
	end

	always_ff @(posedge clk) begin
		if (reset) begin
			decoded.valid <= 1'b0;
		end else if (!halt) begin
			decoded <= dec_next;
		end
	end

endmodule

// ==== verilog/core_execute.sv ====
`timescale 1ns/100ps

module core_execute
	import core_pkg::*;
(
	input logic clk,
	input logic reset,
	input decoded_t decoded,
	output reg_write_t ex_result,
	output redirect_t redirect,
	output reg_write_t wb_write,
	output logic halt
);

	logic live;
	logic known;
	logic writes_reg;
	logic is_jump;
	logic taken;
	word_t alu_result;
	word_t imm_zext;
	word_t imm_sext;

	// Nothing in execute takes effect once the core has halted
	assign live = decoded.valid && !halt;

	assign imm_zext = {8'h00, decoded.imm};
	assign imm_sext = {{8{decoded.imm[7]}}, decoded.imm};

	always_comb begin
		alu_result = '0;
		writes_reg = 1'b0;
		is_jump = 1'b0;
		known = 1'b1;
		case (decoded.opcode)
			op_sub: begin
				alu_result = decoded.va - decoded.vb;
				writes_reg = 1'b1;
			end
			op_add: begin
				alu_result = decoded.va + decoded.vb;
				writes_reg = 1'b1;
			end
			op_inc: begin
				alu_result = decoded.vt + imm_zext;
				writes_reg = 1'b1;
			end
			op_dec: begin
				alu_result = decoded.vt - imm_zext;
				writes_reg = 1'b1;
			end
			op_cmp: begin
				alu_result = (decoded.va == decoded.vb) ? 16'd1 : 16'd0;
				writes_reg = 1'b1;
			end
			op_movl: begin
				alu_result = imm_sext;
				writes_reg = 1'b1;
			end
			op_movh: begin
				// New high byte over the old low byte of rt
				alu_result = {decoded.imm, decoded.vt[7:0]};
				writes_reg = 1'b1;
			end
			op_jump: begin
				is_jump = 1'b1;
				known = decoded.xop inside {xop_jz, xop_jnz, xop_js, xop_jns};
			end
			default: begin
				known = 1'b0;
			end
		endcase
	end

	// Jump conditions look at ra only
	always_comb begin
		case (decoded.xop)
			xop_jz: taken = decoded.va == '0;
			xop_jnz: taken = decoded.va != '0;
			xop_js: taken = decoded.va[15];
			xop_jns: taken = !decoded.va[15];
			default: taken = 1'b0;
		endcase
	end

	assign ex_result.wen = live && writes_reg && decoded.rt != '0;
	assign ex_result.addr = decoded.rt;
	assign ex_result.data = alu_result;

	assign redirect.en = live && is_jump && taken;
	assign redirect.target = decoded.vt;

	always_ff @(posedge clk) begin
		if (reset) begin
			wb_write.wen <= 1'b0;
			halt <= 1'b0;
		end else begin
			wb_write <= ex_result;
			// Sticky until the next reset
			if (live && !known)
				halt <= 1'b1;
		end
	end

endmodule

// ==== verilog/core_fetch.sv ====
`timescale 1ns/100ps

module core_fetch
	import core_pkg::*;
(
	input logic clk,
	input logic reset,
	input logic halt,
	input redirect_t redirect,
	output imem_addr_t imem_addr,
	output pc_t fetch_pc,
	output logic fetch_valid
);

	pc_t pc;
	pc_t pc_next;

	// Static prediction of the next sequential instruction unless execute
	// resolves a taken jump
	assign pc_next = redirect.en ? redirect.target : pc + pc_step;

	assign imem_addr = pc[15:1];

	// The memory answers one cycle later, so the PC of the request travels
	// alongside it into decode
	always_ff @(posedge clk) begin
		if (reset) begin
			pc <= '0;
			fetch_valid <= 1'b0;
		end else if (!halt) begin
			pc <= pc_next;
			fetch_pc <= pc;
			// The word now in flight is on the wrong path after a redirect
			fetch_valid <= !redirect.en;
		end
	end

endmodule

// ==== verilog/core_pkg.sv ====
package core_pkg;

	typedef logic [15:0] word_t;
	typedef logic [15:0] pc_t;
	// Instruction memory is addressed in words, so bit 0 of the PC is dropped
	typedef logic [14:0] imem_addr_t;
	typedef logic [3:0] reg_addr_t;
	typedef logic [7:0] imm_t;
	typedef logic [3:0] opcode_t;
	typedef logic [3:0] xop_t;

	// Opcodes in bits 15 to 12 of the instruction
	localparam opcode_t op_sub = 4'd0;
	localparam opcode_t op_add = 4'd1;
	localparam opcode_t op_inc = 4'd2;
	localparam opcode_t op_dec = 4'd3;
	localparam opcode_t op_cmp = 4'd5;
	localparam opcode_t op_movl = 4'd8;
	localparam opcode_t op_movh = 4'd9;
	localparam opcode_t op_jump = 4'd14;

	// Jump conditions, selected by bits 7 to 4 of a jump
	localparam xop_t xop_jz = 4'd0;
	localparam xop_t xop_jnz = 4'd1;
	localparam xop_t xop_js = 4'd2;
	localparam xop_t xop_jns = 4'd3;

	localparam pc_t pc_step = 16'd2;

	typedef struct packed {
		logic wen;
		reg_addr_t addr;
		word_t data;
	} reg_write_t;

	// Operands are already forwarded when they enter execute
	typedef struct packed {
		logic valid;
		pc_t pc;
		opcode_t opcode;
		xop_t xop;
		imm_t imm;
		reg_addr_t rt;
		word_t va;
		word_t vb;
		word_t vt;
	} decoded_t;

	typedef struct packed {
		logic en;
		pc_t target;
	} redirect_t;

endpackage

// ==== verilog/core_regfile.sv ====
`timescale 1ns/100ps

module core_regfile
	import core_pkg::*;
(
	input logic clk,
	input reg_addr_t rd_addr_a,
	input reg_addr_t rd_addr_b,
	output word_t rd_data_a,
	output word_t rd_data_b,
	input reg_write_t write
);

	// Register 0 has no storage
	word_t regs [1:15];

	always_ff @(posedge clk) begin
		if (write.wen && write.addr != '0) begin
			regs[write.addr] <= write.data;
		end
	end

	// A write in this cycle is seen by a read of the same register
	function automatic word_t read_port(reg_addr_t addr);
		if (addr == '0)
			return '0;
		if (write.wen && write.addr == addr)
			return write.data;
		return regs[addr];
	endfunction

	assign rd_data_a = read_port(rd_addr_a);
	assign rd_data_b = read_port(rd_addr_b);

endmodule

// ==== verilog/core_top.sv ====
`timescale 1ns/100ps

module core_top
	import core_pkg::*;
(
	input logic clk,
	input logic reset,
	output imem_addr_t imem_addr,
	input word_t imem_data,
	output reg_write_t reg_write,
	output logic halt
);

	redirect_t redirect;
	pc_t fetch_pc;
	logic fetch_valid;
	reg_write_t ex_result;
	decoded_t decoded;

	core_fetch fetch_i (
		.clk(clk),
		.reset(reset),
		.halt(halt),
		.redirect(redirect),
		.imem_addr(imem_addr),
		.fetch_pc(fetch_pc),
		.fetch_valid(fetch_valid)
	);

	// The writeback register feeds both the register file and the port
	core_decode decode_i (
		.clk(clk),
		.reset(reset),
		.halt(halt),
		.redirect(redirect),
		.fetch_pc(fetch_pc),
		.fetch_valid(fetch_valid),
		.imem_data(imem_data),
		.ex_result(ex_result),
		.wb_write(reg_write),
		.decoded(decoded)
	);

	core_execute execute_i (
		.clk(clk),
		.reset(reset),
		.decoded(decoded),
		.ex_result(ex_result),
		.redirect(redirect),
		.wb_write(reg_write),
		.halt(halt)
	);

endmodule
